// ==== verilog/attn_pkg.sv ====
`default_nettype none

package attn_pkg;

	// Lane count and Q8.8 number format
	localparam int lane_count = 32;
	localparam int fix_width = 16;
	localparam int frac_bits = 8;
	localparam int prod_width = 2 * fix_width;

	// Multiplier register plus two adder tree register stages
	localparam int engine_latency = 3;

	typedef logic signed [fix_width-1:0] fix_t;

	// Lane 0 sits in the low 16 bits
	typedef struct packed {
		fix_t [lane_count-1:0] lanes;
	} row_t;

	typedef struct packed {
		logic valid;
		row_t row;
	} row_beat_t;

	typedef struct packed {
		logic valid;
		fix_t value;
	} result_t;

endpackage

`default_nettype wire

// ==== verilog/apb_pkg.sv ====
`default_nettype none

package apb_pkg;

	localparam int apb_addr_width = 8;
	localparam int apb_data_width = 32;

	// Result counter width in the status register
	localparam int count_width = 16;

	// Two Q8.8 weights per 32-bit word
	localparam int weight_words = 16;
	localparam int weight_idx_width = $clog2(weight_words);
	localparam logic [apb_addr_width-1:0] weight_span = apb_addr_width'(weight_words * 4);

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [apb_addr_width-1:0] paddr;
		logic [apb_data_width-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [apb_data_width-1:0] prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	typedef enum logic [apb_addr_width-1:0] {
		ctrl_addr = 8'h00,
		status_addr = 8'h04,
		weight_base = 8'h40
	} reg_addr_e;

endpackage

`default_nettype wire

// ==== verilog/lane_multiplier.sv ====
`default_nettype none

module lane_multiplier (
	input logic clk,
	input attn_pkg::row_t a,
	input attn_pkg::row_t b,
	output attn_pkg::row_t products
);
	import attn_pkg::*;

	row_t prod_next;

	// One signed multiplier per lane
	for (genvar i = 0; i < lane_count; i++) begin : g_lane
		fix_t op_a;
		fix_t op_b;
		logic signed [prod_width-1:0] full;

		assign op_a = a.lanes[i];
		assign op_b = b.lanes[i];
		assign full = op_a * op_b;

		// Arithmetic shift by the fraction bits, then keep 16 bits
		assign prod_next.lanes[i] = full[frac_bits +: fix_width];
	end

	// Output register stage for all lanes
	always_ff @(posedge clk) begin
		products <= prod_next;
	end

endmodule

`default_nettype wire

// ==== verilog/adder_tree.sv ====
`default_nettype none

module adder_tree (
	input logic clk,
	input logic reset,
	input attn_pkg::row_t terms,
	output attn_pkg::fix_t sum
);
	import attn_pkg::*;

	fix_t lvl1 [lane_count/2];
	fix_t lvl2 [lane_count/4];
	fix_t mid_q [lane_count/4];
	fix_t lvl3 [lane_count/8];
	fix_t lvl4 [lane_count/16];
	fix_t root;

	// Level one adds neighbouring lanes
	for (genvar i = 0; i < lane_count / 2; i++) begin : g_lvl1
		assign lvl1[i] = terms.lanes[2 * i] + terms.lanes[2 * i + 1];
	end

	for (genvar i = 0; i < lane_count / 4; i++) begin : g_lvl2
		assign lvl2[i] = lvl1[2 * i] + lvl1[2 * i + 1];
	end

	// Register the eight partial sums
	always_ff @(posedge clk) begin
		for (int i = 0; i < lane_count / 4; i++) begin
			mid_q[i] <= lvl2[i];
		end
	end

	for (genvar i = 0; i < lane_count / 8; i++) begin : g_lvl3
		assign lvl3[i] = mid_q[2 * i] + mid_q[2 * i + 1];
	end

	for (genvar i = 0; i < lane_count / 16; i++) begin : g_lvl4
		assign lvl4[i] = lvl3[2 * i] + lvl3[2 * i + 1];
	end

	// Sums wrap modulo 2^16, so pairing order does not matter
	assign root = lvl4[0] + lvl4[1];

	always_ff @(posedge clk) begin
		if (!reset) begin
			sum <= '0;
		end else begin
			sum <= root;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/vec_dot_engine.sv ====
`default_nettype none

module vec_dot_engine (
	input logic clk,
	input logic reset,
	input attn_pkg::row_beat_t beat,
	input logic accept,
	input attn_pkg::row_t weights,
	output attn_pkg::result_t result
);
	import attn_pkg::*;

	row_t products;
	fix_t tree_sum;
	logic [engine_latency-1:0] valid_pipe;

	// Weights sampled on the same edge as the row
	lane_multiplier u_mult (
		.clk(clk),
		.a(weights),
		.b(beat.row),
		.products(products)
	);

	adder_tree u_tree (
		.clk(clk),
		.reset(reset),
		.terms(products),
		.sum(tree_sum)
	);

	// Valid flag follows the data through the three register stages
	always_ff @(posedge clk) begin
		if (!reset) begin
			valid_pipe <= '0;
		end else begin
			valid_pipe <= {valid_pipe[engine_latency-2:0], beat.valid & accept};
		end
	end

	assign result.valid = valid_pipe[engine_latency-1];
	assign result.value = tree_sum;

endmodule

`default_nettype wire

// ==== verilog/weight_regs.sv ====
`default_nettype none

module weight_regs (
	input logic clk,
	input logic reset,
	input apb_pkg::apb_req_t apb_req,
	output apb_pkg::apb_rsp_t apb_rsp,
	input logic result_valid,
	output logic enable,
	output attn_pkg::row_t weights
);
	import attn_pkg::*;
	import apb_pkg::*;

	logic [apb_data_width-1:0] weight_q [weight_words];
	logic [count_width-1:0] result_count;
	logic [apb_addr_width-1:0] weight_offset;
	logic [weight_idx_width-1:0] word_idx;
	logic access;
	logic is_ctrl;
	logic is_status;
	logic is_weight;
	logic addr_err;
	logic wr_en;
	logic [apb_data_width-1:0] rd_data;

	// No wait states, so every access cycle completes
	assign access = apb_req.psel & apb_req.penable;

	// Addresses below the weight window wrap to a large offset
	assign weight_offset = apb_req.paddr - weight_base;
	assign word_idx = weight_offset[2 +: weight_idx_width];

	always_comb begin
		is_ctrl = 1'b0;
		is_status = 1'b0;
		case (apb_req.paddr)
			ctrl_addr: begin
				is_ctrl = 1'b1;
			end
			status_addr: begin
				is_status = 1'b1;
			end
			default: begin
				is_ctrl = 1'b0;
			end
		endcase
	end

	assign is_weight = (weight_offset < weight_span) && (weight_offset[1:0] == 2'b00);

	// Status is read-only
	assign addr_err = ~(is_ctrl | is_status | is_weight) | (apb_req.pwrite & is_status);
	assign wr_en = access & apb_req.pwrite & ~addr_err;

	always_ff @(posedge clk) begin
		if (!reset) begin
			enable <= 1'b0;
			for (int k = 0; k < weight_words; k++) begin
				weight_q[k] <= '0;
			end
		end else if (wr_en) begin
			if (is_ctrl) begin
				enable <= apb_req.pwdata[0];
			end
			if (is_weight) begin
				weight_q[word_idx] <= apb_req.pwdata;
			end
		end
	end

	// Counts results leaving the engine, wraps at 2^16
	always_ff @(posedge clk) begin
		if (!reset) begin
			result_count <= '0;
		end else if (result_valid) begin
			result_count <= result_count + 1'b1;
		end
	end

	always_comb begin
		rd_data = '0;
		if (is_ctrl) begin
			rd_data[0] = enable;
		end else if (is_status) begin
			rd_data[count_width-1:0] = result_count;
		end else if (is_weight) begin
			rd_data = weight_q[word_idx];
		end
	end

	assign apb_rsp.prdata = rd_data;
	assign apb_rsp.pready = access;
	assign apb_rsp.pslverr = access & addr_err;

	// Even lane in the low half of each word
	for (genvar k = 0; k < weight_words; k++) begin : g_unpack
		assign weights.lanes[2 * k] = weight_q[k][fix_width-1:0];
		assign weights.lanes[2 * k + 1] = weight_q[k][apb_data_width-1:fix_width];
	end

endmodule

`default_nettype wire

// ==== verilog/attn_value_top.sv ====
`default_nettype none

module attn_value_top (
	input logic clk,
	input logic reset,
	input apb_pkg::apb_req_t apb_req,
	output apb_pkg::apb_rsp_t apb_rsp,
	input attn_pkg::row_beat_t row_in,
	output logic row_ready,
	output attn_pkg::result_t result_out
);
	import attn_pkg::*;

	row_t weights;

	// Register block, enable doubles as the row ready
	weight_regs u_regs (
		.clk(clk),
		.reset(reset),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.result_valid(result_out.valid),
		.enable(row_ready),
		.weights(weights)
	);

	// Dot product pipeline
	vec_dot_engine u_engine (
		.clk(clk),
		.reset(reset),
		.beat(row_in),
		.accept(row_ready),
		.weights(weights),
		.result(result_out)
	);

endmodule

`default_nettype wire

// ==== sim/attn_value_assert.sv ====
`default_nettype none

module attn_value_assert (
	input logic clk,
	input logic reset,
	input apb_pkg::apb_req_t apb_req,
	input apb_pkg::apb_rsp_t apb_rsp,
	input attn_pkg::row_beat_t row_in,
	input logic row_ready,
	input attn_pkg::result_t result_out
);
	import attn_pkg::*;
	import apb_pkg::*;

	// Pipeline is empty right after a reset edge
	result_cleared: assert property (@(posedge clk) !reset |=> !result_out.valid)
		else $error("result_out.valid high in the cycle after reset");

	// No wait states and no response outside an access cycle
	pready_in_access: assert property (@(posedge clk)
		apb_rsp.pready |-> (apb_req.psel && apb_req.penable))
		else $error("pready high outside an APB access cycle");

	result_latency: assert property (@(posedge clk) disable iff (!reset)
		(row_in.valid && row_ready) |-> ##3 result_out.valid)
		else $error("accepted row gave no result three cycles later");

endmodule

bind attn_value_top attn_value_assert u_assert (.*);

`default_nettype wire

// ==== sim/attn_value_tb.sv ====
`default_nettype none

module attn_value_tb;
	import attn_pkg::*;
	import apb_pkg::*;

	localparam int random_rows = 200;
	localparam int reset_cycles = 16;
	localparam string vector_path = "sim/attn_vectors.txt";

	logic clk;
	logic reset;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	row_beat_t row_in;
	logic row_ready;
	result_t result_out;

	int cycle = 0;
	int limit = 1000000;
	int checks = 0;
	int errors = 0;
	int test_start_errors = 0;
	int accepted = 0;
	logic test_open = 1'b0;
	string test_name;
	logic model_en = 1'b0;
	logic [15:0] model_w [lane_count];
	logic [15:0] exp_val_q [$];
	int exp_cyc_q [$];

	attn_value_top uut (
		.clk(clk),
		.reset(reset),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.row_in(row_in),
		.row_ready(row_ready),
		.result_out(result_out)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= limit) begin
			$display("Timeout: run stopped after %0d cycles", cycle);
			$display("Something failed");
			$finish;
		end
	end

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_start_errors = errors;
		test_open = 1'b1;
	endtask

	task automatic end_test();
		if (test_open) begin
			if (errors == test_start_errors)
				$display("test %s: passed", test_name);
			else
				$display("test %s: failed with %0d errors", test_name, errors - test_start_errors);
		end
		test_open = 1'b0;
	endtask

	// Truncated Q8.8 products summed modulo 2^16
	function automatic logic [15:0] dot_model(input row_t row);
		logic signed [31:0] full;
		logic signed [31:0] shifted;
		logic [15:0] acc;
		acc = '0;
		for (int i = 0; i < lane_count; i++) begin
			full = 32'($signed(model_w[i])) * 32'($signed(row.lanes[i]));
			shifted = full >>> frac_bits;
			acc = acc + shifted[15:0];
		end
		return acc;
	endfunction

	// All bus tasks start and end on a falling edge
	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite = 1'b1;
		apb_req.paddr = addr;
		apb_req.pwdata = data;
		@(negedge clk);
		apb_req.penable = 1'b1;
		#10;
		compare("apb_rsp.pready", 32'(apb_rsp.pready), 32'd1);
		compare("apb_rsp.pslverr", 32'(apb_rsp.pslverr), 32'(exp_err));
		@(negedge clk);
		apb_req = '0;
	endtask

	task automatic apb_read(input logic [7:0] addr, input logic [31:0] exp_data,
		input logic exp_err);
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite = 1'b0;
		apb_req.paddr = addr;
		apb_req.pwdata = '0;
		@(negedge clk);
		apb_req.penable = 1'b1;
		#10;
		compare("apb_rsp.pready", 32'(apb_rsp.pready), 32'd1);
		compare("apb_rsp.pslverr", 32'(apb_rsp.pslverr), 32'(exp_err));
		compare("apb_rsp.prdata", apb_rsp.prdata, exp_data);
		@(negedge clk);
		apb_req = '0;
	endtask

	// Accepted on the next rising edge and seen at the third falling edge after this one
	task automatic send_row(input row_t row, input logic [15:0] exp);
		compare("row_ready", 32'(row_ready), 32'(model_en));
		row_in.valid = 1'b1;
		row_in.row = row;
		if (model_en) begin
			exp_val_q.push_back(exp);
			exp_cyc_q.push_back(cycle + 3);
			accepted++;
		end
		@(negedge clk);
		row_in.valid = 1'b0;
	endtask

	task automatic drain();
		while (exp_val_q.size() != 0) begin
			@(negedge clk);
		end
	endtask

	function automatic row_t random_row();
		row_t row;
		for (int i = 0; i < lane_count; i++) begin
			row.lanes[i] = 16'($urandom);
		end
		return row;
	endfunction

	always @(negedge clk) begin : result_monitor
		logic [15:0] got_v;
		logic [15:0] exp_v;
		int exp_c;
		if (result_out.valid) begin
			if (exp_val_q.size() == 0) begin
				errors++;
				$display("Result appeared at cycle %0d with no accepted row for it", cycle);
			end else begin
				got_v = result_out.value;
				exp_v = exp_val_q.pop_front();
				exp_c = exp_cyc_q.pop_front();
				compare("result_out.value", 32'(got_v), 32'(exp_v));
				if (exp_c != cycle) begin
					errors++;
					$display("Result arrived at cycle %0d instead of cycle %0d", cycle, exp_c);
				end
			end
		end
	end

	task automatic run_vectors();
		int fd;
		int code;
		int k;
		logic [7:0] tok;
		logic [8*32-1:0] name;
		logic [8*200-1:0] rest;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] err;
		logic [31:0] lane;
		logic [15:0] exp;
		row_t row;
		fd = $fopen(vector_path, "r");
		if (fd == 0) begin
			errors++;
			$display("Could not open the vector file %s", vector_path);
			return;
		end
		while ($fscanf(fd, "%s", tok) == 1) begin
			if (tok == "#") begin
				code = $fgets(rest, fd);
			end else if (tok == "T") begin
				code = $fscanf(fd, "%s", name);
				end_test();
				start_test($sformatf("%0s", name));
			end else if (tok == "W") begin
				code = $fscanf(fd, "%h %h %h", addr, data, err);
				drain();
				apb_write(addr[7:0], data, err[0]);
				if (!err[0] && addr == 32'h00)
					model_en = data[0];
				if (!err[0] && addr >= 32'h40 && addr < 32'h80 && addr[1:0] == 2'b00) begin
					k = int'((addr - 32'h40) >> 2);
					model_w[2 * k] = data[15:0];
					model_w[2 * k + 1] = data[31:16];
				end
			end else if (tok == "R") begin
				code = $fscanf(fd, "%h %h %h", addr, data, err);
				drain();
				apb_read(addr[7:0], data, err[0]);
			end else if (tok == "M") begin
				code = $fscanf(fd, "%h", lane);
				exp = lane[15:0];
				for (int i = 0; i < lane_count; i++) begin
					code = $fscanf(fd, "%h", lane);
					row.lanes[i] = lane[15:0];
				end
				compare("vector file result", 32'(exp), 32'(dot_model(row)));
				send_row(row, dot_model(row));
			end else begin
				errors++;
				$display("Unknown line kind in the vector file");
			end
		end
		$fclose(fd);
		drain();
		end_test();
	endtask

	initial begin
		int fd;
		int code;
		int lines;
		logic [8*200-1:0] line_buf;
		row_t rnd_row;
		clk = 1'b0;
		reset = 1'b0;
		apb_req = '0;
		row_in = '0;
		for (int i = 0; i < lane_count; i++) begin
			model_w[i] = '0;
		end
		void'($urandom(28807));

		// Run length follows from the vector file size
		lines = 0;
		fd = $fopen(vector_path, "r");
		if (fd != 0) begin
			while (!$feof(fd)) begin
				code = $fgets(line_buf, fd);
				if (code > 0)
					lines++;
			end
			$fclose(fd);
		end
		limit = reset_cycles + 10 * lines + 4 * random_rows + 200;

		start_test("reset_state");
		repeat (reset_cycles) begin
			@(negedge clk);
			compare("row_ready", 32'(row_ready), 32'd0);
		end
		reset = 1'b1;
		@(negedge clk);
		compare("row_ready", 32'(row_ready), 32'd0);
		apb_read(ctrl_addr, 32'd0, 1'b0);
		apb_read(status_addr, 32'd0, 1'b0);
		end_test();

		run_vectors();

		start_test("pipelining");
		for (int n = 0; n < random_rows; n++) begin
			rnd_row = random_row();
			send_row(rnd_row, dot_model(rnd_row));
		end
		drain();
		end_test();

		start_test("enable_gating");
		apb_write(ctrl_addr, 32'd0, 1'b0);
		model_en = 1'b0;
		repeat (10) begin
			send_row(random_row(), 16'h0000);
		end
		repeat (6) @(negedge clk);
		apb_read(status_addr, 32'(accepted), 1'b0);
		end_test();

		start_test("result_count");
		apb_write(ctrl_addr, 32'd1, 1'b0);
		model_en = 1'b1;
		repeat (5) begin
			rnd_row = random_row();
			send_row(rnd_row, dot_model(rnd_row));
		end
		drain();
		apb_read(status_addr, 32'(accepted), 1'b0);
		end_test();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
verilog/attn_pkg.sv
verilog/apb_pkg.sv
verilog/lane_multiplier.sv
verilog/adder_tree.sv
verilog/vec_dot_engine.sv
verilog/weight_regs.sv
verilog/attn_value_top.sv
sim/attn_value_assert.sv
sim/attn_value_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# Builds and runs the attention value stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module attn_value_tb -f sim.f -o attn_value_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/attn_value_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -qx "Everything OK" sim.log; then
	exit 0
fi
exit 1

// ==== sim/attn_vectors.txt ====
# T name; W addr data pslverr; R addr expected_data expected_pslverr
# M expected_result, then 32 lanes from lane 0 (hex)
T register_map
W 40 ff000100 0
W 44 02000080 0
W 7c fe800040 0
R 40 ff000100 0
R 44 02000080 0
R 7c fe800040 0
R 48 00000000 0
R 08 00000000 1
R 80 00000000 1
W 04 00001234 1
R 04 00000000 0
T single_dot
W 00 00000001 0
R 00 00000001 0
M 0200
0300 0100 0400 ff80 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0800 0200
M fffb
ffff 0000 0001 ffff 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0001
M f000
7000 8000 4000 7000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
R 04 00000003 0
